/* Bender.yml */
package:
  name: dht22_host

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/dht22_pkg.sv
      - hw/dht22_frame_if.sv
      - hw/dht22_line_ctrl.sv
      - hw/dht22_wb_regs.sv
      - hw/dht22_host.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/dht22_props.sv
      - sim/dht22_tb.sv

/* hw/dht22_defs.svh */
`ifndef DHT22_DEFS_SVH
`define DHT22_DEFS_SVH

// system clock of 50 MHz
`define DHT22_CLK_PER_US 50

// host wake-up pulse, kept above 1 ms
`define DHT22_START_US 1100

// longer high phases decode as a one
`define DHT22_BIT_ONE_US 48

// longest single level before the frame is dropped
`define DHT22_TIMEOUT_US 200

// 16 humidity bits, 16 temperature bits, 8 checksum bits
`define DHT22_FRAME_BITS 40

// register byte addresses
`define DHT22_ADDR_CTRL 4'h0
`define DHT22_ADDR_STATUS 4'h4
`define DHT22_ADDR_DATA 4'h8
`define DHT22_ADDR_SUM 4'hC

`endif

/* hw/dht22_frame_if.sv */
`timescale 1ns/1ps

interface dht22_frame_if;
    import dht22_pkg::*;

    // one-cycle request, only while busy is low
    logic start;
    // high from the cycle after start until done
    logic busy;
    // one-cycle end of frame
    logic done;
    // qualifies done
    logic timeout;
    // valid in the done cycle only
    dht22_frame_t frame;

    modport regs (
        output start,
        input  busy,
        input  done,
        input  timeout,
        input  frame
    );

    modport line (
        input  start,
        output busy,
        output done,
        output timeout,
        output frame
    );

endinterface

/* hw/dht22_host.sv */
`timescale 1ns/1ps

module dht22_host (
    input  logic        dht22_vif,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    inout  wire         dht22_in_out
);

    // start/done handshake between bus side and line side
    dht22_frame_if frame_bus ();

    dht22_wb_regs i_regs (
        .dht22_vif (dht22_vif),
        .reset     (reset),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .frame_bus (frame_bus.regs)
    );

    // sole driver of the sensor line
    dht22_line_ctrl i_line (
        .dht22_vif    (dht22_vif),
        .reset        (reset),
        .frame_bus    (frame_bus.line),
        .dht22_in_out (dht22_in_out)
    );

endmodule

/* hw/dht22_line_ctrl.sv */
`timescale 1ns/1ps
`include "dht22_defs.svh"

module dht22_line_ctrl (
    input  logic        dht22_vif,
    input  logic        reset,
    dht22_frame_if.line frame_bus,
    inout  wire         dht22_in_out
);
    import dht22_pkg::*;

    localparam int START_CYC   = `DHT22_START_US * `DHT22_CLK_PER_US;
    localparam int TIMEOUT_CYC = `DHT22_TIMEOUT_US * `DHT22_CLK_PER_US;
    localparam int BIT_ONE_CYC = `DHT22_BIT_ONE_US * `DHT22_CLK_PER_US;
    localparam int CNT_W       = $clog2(START_CYC + 1);
    localparam int BIT_W       = $clog2(`DHT22_FRAME_BITS + 1);

    localparam logic [CNT_W-1:0] START_LAST   = CNT_W'(START_CYC - 1);
    localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(TIMEOUT_CYC - 1);
    localparam logic [CNT_W-1:0] BIT_ONE_LIM  = CNT_W'(BIT_ONE_CYC);
    // our own low level is still in the synchronizer right after release
    localparam logic [CNT_W-1:0] GUARD_LAST   = CNT_W'(`DHT22_CLK_PER_US);
    localparam logic [BIT_W-1:0] LAST_BIT     = BIT_W'(`DHT22_FRAME_BITS - 1);

    dht22_line_state_t state;
    logic [CNT_W-1:0] cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic line_meta;
    logic line_sync;
    logic timeout_q;
    logic [`DHT22_FRAME_BITS-1:0] shift_q;
    logic waiting;
    logic expired;

    // open drain, never drive high
    assign dht22_in_out = (state == st_start_low) ? 1'b0 : 1'bz;

    always_ff @(posedge dht22_vif) begin
        if (reset) begin
            line_meta <= 1'b1;
            line_sync <= 1'b1;
        end else begin
            line_meta <= dht22_in_out;
            line_sync <= line_meta;
        end
    end

    // states that wait on the sensor
    assign waiting = (state == st_release) || (state == st_ack_low) ||
                     (state == st_ack_high) || (state == st_bit_low) ||
                     (state == st_bit_high);
    assign expired = (cnt == TIMEOUT_LAST);

    always_ff @(posedge dht22_vif) begin
        if (reset) begin
            state     <= st_idle;
            cnt       <= '0;
            bit_cnt   <= '0;
            timeout_q <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (frame_bus.start) begin
                        state     <= st_start_low;
                        bit_cnt   <= '0;
                        timeout_q <= 1'b0;
                    end
                end
                st_start_low: begin
                    if (cnt == START_LAST) begin
                        state <= st_release;
                        cnt   <= '0;
                    end
                end
                st_release: begin
                    if (!line_sync && cnt >= GUARD_LAST) begin
                        state <= st_ack_low;
                        cnt   <= '0;
                    end
                end
                st_ack_low: begin
                    if (line_sync) begin
                        state <= st_ack_high;
                        cnt   <= '0;
                    end
                end
                st_ack_high: begin
                    if (!line_sync) begin
                        state <= st_bit_low;
                        cnt   <= '0;
                    end
                end
                st_bit_low: begin
                    if (line_sync) begin
                        state <= st_bit_high;
                        cnt   <= '0;
                    end
                end
                st_bit_high: begin
                    // falling edge closes the bit
                    if (!line_sync) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        cnt     <= '0;
                        state   <= (bit_cnt == LAST_BIT) ? st_finish : st_bit_low;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            // a stuck level wins over any edge in the same cycle
            if (waiting && expired) begin
                state     <= st_finish;
                timeout_q <= 1'b1;
            end
        end
    end

    // msb first, high phase length decides the bit
    always_ff @(posedge dht22_vif) begin
        if (state == st_bit_high && !line_sync) begin
            shift_q <= {shift_q[`DHT22_FRAME_BITS-2:0], (cnt > BIT_ONE_LIM)};
        end
    end

    assign frame_bus.busy    = (state != st_idle) && (state != st_finish);
    assign frame_bus.done    = (state == st_finish);
    assign frame_bus.timeout = timeout_q;
    assign frame_bus.frame   = dht22_frame_t'(shift_q);

endmodule

/* hw/dht22_pkg.sv */
`include "dht22_defs.svh"

package dht22_pkg;

    // single-wire line controller states
    typedef enum logic [2:0] {
        st_idle,
        st_start_low,
        st_release,
        st_ack_low,
        st_ack_high,
        st_bit_low,
        st_bit_high,
        st_finish
    } dht22_line_state_t;

    // word index taken from byte address bits [3:2]
    typedef enum logic [1:0] {
        reg_ctrl   = 2'(`DHT22_ADDR_CTRL >> 2),
        reg_status = 2'(`DHT22_ADDR_STATUS >> 2),
        reg_data   = 2'(`DHT22_ADDR_DATA >> 2),
        reg_sum    = 2'(`DHT22_ADDR_SUM >> 2)
    } dht22_reg_t;

    // sensor frame in wire order, first bit received is the MSB
    typedef struct packed {
        logic [15:0] humidity;
        logic [15:0] temperature;
        logic [7:0]  checksum;
    } dht22_frame_t;

endpackage

/* hw/dht22_wb_regs.sv */
`timescale 1ns/1ps

module dht22_wb_regs (
    input  logic        dht22_vif,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    dht22_frame_if.regs frame_bus
);
    import dht22_pkg::*;

    dht22_reg_t reg_sel;
    logic access;
    logic word_hit;
    logic ctrl_go;
    logic conv_busy;
    logic valid;
    logic cks_err;
    logic tmo_err;
    logic [31:0] data_q;
    logic [7:0] sum_q;
    logic [7:0] byte_sum;
    logic sum_ok;

    // first cycle of a strobe, the ack cycle after it is dead
    assign access   = wb_cyc && wb_stb && !wb_ack;
    assign reg_sel  = dht22_reg_t'(wb_adr[3:2]);
    assign word_hit = (wb_adr[1:0] == 2'b00);

    // done still counts as busy until status has caught up
    assign conv_busy = frame_bus.busy || frame_bus.done;

    assign ctrl_go = access && wb_we && word_hit && (reg_sel == reg_ctrl) &&
                     wb_wdata[0] && !conv_busy;

    // byte sum of humidity and temperature, low 8 bits only
    assign byte_sum = frame_bus.frame.humidity[15:8] + frame_bus.frame.humidity[7:0] +
                      frame_bus.frame.temperature[15:8] + frame_bus.frame.temperature[7:0];
    assign sum_ok   = (byte_sum == frame_bus.frame.checksum);

    always_ff @(posedge dht22_vif) begin
        if (reset) begin
            wb_ack          <= 1'b0;
            frame_bus.start <= 1'b0;
            valid           <= 1'b0;
            cks_err         <= 1'b0;
            tmo_err         <= 1'b0;
        end else begin
            wb_ack          <= access;
            frame_bus.start <= ctrl_go;
            if (ctrl_go) begin
                valid   <= 1'b0;
                cks_err <= 1'b0;
                tmo_err <= 1'b0;
            end else if (frame_bus.done) begin
                // a cut frame only reports the timeout
                valid   <= !frame_bus.timeout && sum_ok;
                cks_err <= !frame_bus.timeout && !sum_ok;
                tmo_err <= frame_bus.timeout;
            end
        end
    end

    always_ff @(posedge dht22_vif) begin
        if (frame_bus.done) begin
            data_q <= {frame_bus.frame.humidity, frame_bus.frame.temperature};
            sum_q  <= frame_bus.frame.checksum;
        end
    end

    // read data lands in the ack cycle
    always_ff @(posedge dht22_vif) begin
        if (access && !wb_we) begin
            if (!word_hit) begin
                wb_rdata <= '0;
            end else begin
                case (reg_sel)
                    reg_status: wb_rdata <= {28'b0, tmo_err, cks_err, valid, conv_busy};
                    reg_data:   wb_rdata <= data_q;
                    reg_sum:    wb_rdata <= {24'b0, sum_q};
                    default:    wb_rdata <= '0;
                endcase
            end
        end
    end

endmodule

/* sim/dht22_props.sv */
`timescale 1ns/1ps
`include "dht22_defs.svh"

module dht22_props (
    input logic dht22_vif,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic dht22_in_out,
    input logic start,
    input logic busy,
    input logic done
);

    localparam int START_CYC = `DHT22_START_US * `DHT22_CLK_PER_US;

    logic armed;
    int unsigned low_cnt;

    // length of the low level that follows a start request
    always @(posedge dht22_vif) begin
        if (reset) begin
            armed   <= 1'b0;
            low_cnt <= 0;
        end else if (start) begin
            armed   <= 1'b1;
            low_cnt <= 0;
        end else if (armed) begin
            if (dht22_in_out === 1'b0) begin
                low_cnt <= low_cnt + 1;
            end else begin
                armed <= 1'b0;
            end
        end
    end

    a_start_len: assert property (@(posedge dht22_vif) disable iff (reset)
        (armed && dht22_in_out === 1'b1) |-> (low_cnt >= START_CYC))
        else $error("start pulse ended after %0d cycles", low_cnt);

    a_ack_single: assert property (@(posedge dht22_vif) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wb_ack high two cycles in a row");

    a_ack_strobe: assert property (@(posedge dht22_vif) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack without a strobe");

    a_done_busy: assert property (@(posedge dht22_vif) disable iff (reset)
        done |-> $past(busy))
        else $error("done outside a conversion");

endmodule

bind dht22_host dht22_props i_props (
    .dht22_vif    (dht22_vif),
    .reset        (reset),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack),
    .dht22_in_out (dht22_in_out),
    .start        (frame_bus.start),
    .busy         (frame_bus.busy),
    .done         (frame_bus.done)
);

/* sim/dht22_tb.sv */
`timescale 1ns/1ps
`include "dht22_defs.svh"

module dht22_tb;
    import dht22_pkg::*;

    localparam int N_FRAMES    = 7;
    // worst case frame with all ones, rounded up
    localparam int FRAME_US    = 6400;
    localparam int CYCLE_LIMIT = (N_FRAMES + 3) * FRAME_US * `DHT22_CLK_PER_US;
    localparam real START_NS   = `DHT22_START_US * 1000.0;

    logic dht22_vif;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [3:0] wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic wb_ack;
    logic sensor_low;
    logic [31:0] lfsr_q;
    int cycles;
    int n;
    int kind;
    bit poke;
    wire dht22_in_out;

    // open-drain bus with the external resistor
    pullup (dht22_in_out);
    assign dht22_in_out = sensor_low ? 1'b0 : 1'bz;

    dht22_host i_dut (
        .dht22_vif    (dht22_vif),
        .reset        (reset),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_wdata     (wb_wdata),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .dht22_in_out (dht22_in_out)
    );

    initial begin
        dht22_vif = 1'b0;
        forever #10 dht22_vif = ~dht22_vif;
    end

    always @(posedge dht22_vif) cycles <= cycles + 1;

    initial begin
        wait (cycles >= CYCLE_LIMIT);
        $display("timeout: run still going after %0d cycles", cycles);
        $display("Something failed");
        $fatal(1, "simulation timeout");
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, got, exp);
            $display("Something failed");
            $fatal(1, "first error");
        end
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int nb);
        logic [31:0] val;
        int i;
        val = '0;
        for (i = 0; i < nb; i++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return val;
    endfunction

    // low byte of the sum over the four data bytes
    function automatic logic [7:0] calc_checksum(input logic [15:0] hum, input logic [15:0] tmp);
        logic [31:0] word;
        logic [7:0] acc;
        int i;
        word = {hum, tmp};
        acc = '0;
        for (i = 0; i < 4; i++) begin
            acc = acc + word[8*i +: 8];
        end
        return acc;
    endfunction

    // status word once busy has dropped, one error kind per frame kind
    function automatic logic [31:0] expected_status(input int k);
        case (k)
            1: return 32'h4;
            2: return 32'h8;
            default: return 32'h2;
        endcase
    endfunction

    task automatic wait_cycles(input int cnt);
        repeat (cnt) @(posedge dht22_vif);
        #2;
    endtask

    task automatic hold_line(input logic low, input int us);
        sensor_low = low;
        wait_cycles(us * `DHT22_CLK_PER_US);
    endtask

    // strobe stays up through the cycle after the ack
    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        wait_cycles(1);
        check(wb_ack, 1'b1, "no ack in the cycle after the strobe");
        rdata = wb_rdata;
        wait_cycles(1);
        check(wb_ack, 1'b0, "ack held for a second cycle");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // sensor side: measure the wake-up pulse, then answer with nbits bits
    task automatic sensor_answer(input dht22_frame_t f, input int nbits);
        realtime t_low;
        logic [39:0] bits;
        int i;
        bits = f;
        @(negedge dht22_in_out);
        t_low = $realtime;
        @(posedge dht22_in_out);
        check(($realtime - t_low) >= START_NS, 1'b1, "start pulse shorter than 1100 us");
        #2;
        hold_line(1'b0, 20);
        check(dht22_in_out, 1'b1, "line not released after the start pulse");
        hold_line(1'b1, 80);
        hold_line(1'b0, 80);
        for (i = 0; i < nbits; i++) begin
            hold_line(1'b1, 50);
            hold_line(1'b0, bits[39 - i] ? 70 : 25);
        end
        // full frames end with a short low, cut frames just let go
        if (nbits == `DHT22_FRAME_BITS) begin
            hold_line(1'b1, 50);
        end
        sensor_low = 1'b0;
    endtask

    task automatic run_frame(input int k, input bit busy_write);
        dht22_frame_t f;
        logic [31:0] rd;
        f.humidity    = rand_bits(16);
        f.temperature = rand_bits(16);
        f.checksum    = calc_checksum(f.humidity, f.temperature);
        if (k == 1) begin
            f.checksum = f.checksum ^ (rand_bits(8) | 8'h01);
        end
        fork
            sensor_answer(f, (k == 2) ? 16 : `DHT22_FRAME_BITS);
            begin
                wb_access(1'b1, `DHT22_ADDR_CTRL, 32'h1, rd);
                wb_access(1'b0, `DHT22_ADDR_STATUS, 32'h0, rd);
                check(rd[0], 1'b1, "busy not set after start");
                if (busy_write) begin
                    // lands in the middle of the data bits
                    wait_cycles(1500 * `DHT22_CLK_PER_US);
                    wb_access(1'b1, `DHT22_ADDR_CTRL, 32'h1, rd);
                    wb_access(1'b0, `DHT22_ADDR_STATUS, 32'h0, rd);
                    check(rd[0], 1'b1, "busy lost after a write during conversion");
                end
            end
        join
        do begin
            wait_cycles(10 * `DHT22_CLK_PER_US);
            wb_access(1'b0, `DHT22_ADDR_STATUS, 32'h0, rd);
        end while (rd[0]);
        check(rd, expected_status(k), "status after frame");
        if (k != 2) begin
            wb_access(1'b0, `DHT22_ADDR_DATA, 32'h0, rd);
            check(rd, {f.humidity, f.temperature}, "data register");
            wb_access(1'b0, `DHT22_ADDR_SUM, 32'h0, rd);
            check(rd, {24'b0, f.checksum}, "sum register");
        end
    endtask

    initial begin
        cycles     = 0;
        lfsr_q     = 32'haee3;
        reset      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_wdata   = '0;
        sensor_low = 1'b0;
        repeat (3) @(posedge dht22_vif);
        #2;
        reset = 1'b0;
        wait_cycles(2);
        // first three frames cover each kind, the rest are drawn
        for (n = 0; n < N_FRAMES; n++) begin
            kind = (n < 3) ? n : int'(rand_bits(2));
            if (kind == 3) begin
                kind = 0;
            end
            poke = (n == 0) || rand_bits(1);
            run_frame(kind, poke);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

/* src.f */
+incdir+hw
hw/dht22_pkg.sv
hw/dht22_frame_if.sv
hw/dht22_line_ctrl.sv
hw/dht22_wb_regs.sv
hw/dht22_host.sv
sim/dht22_props.sv
sim/dht22_tb.sv
